/* Bender.yml */
package:
  name: issue_stage

export_include_dirs:
  - logic

sources:
  - files:
      - logic/issue_pkg.sv
      - logic/multiport_ram.sv
      - logic/first_k_select.sv
      - logic/reg_status.sv
      - logic/issue_queue.sv
      - logic/issue_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/issue_tb.sv

/* list.f */
+incdir+logic
logic/issue_pkg.sv
logic/multiport_ram.sv
logic/first_k_select.sv
logic/reg_status.sv
logic/issue_queue.sv
logic/issue_top.sv
tests/issue_tb.sv

/* logic/first_k_select.sv */
`timescale 1ns/10ps
`default_nettype none

module first_k_select #(
    parameter int width = 8,
    parameter int k     = 2
) (
    input  logic [width-1:0]               bits,
    output logic [k-1:0][$clog2(width):0]  pos    // {found, index} per pick
);
    localparam int idx_w = $clog2(width);

    // lowest index first, unused picks stay all zero
    always_comb begin
        int n;
        pos = '0;
        n   = 0;
        for (int i = 0; i < width; i++) begin
            if (bits[i] && n < k) begin
                pos[n] = {1'b1, idx_w'(i)};
                n++;                          // next pick slot
            end
        end
    end

endmodule

`default_nettype wire

/* logic/issue_config.svh */
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// rename lanes offered per cycle
`define REN_WIDTH 2

// issue lanes per class, also the number of write-back lanes
`define EXE_WIDTH 2

// issue queue entries
`define IQ_DEPTH 8

// physical registers, p0 is hardwired zero
`define PREG_COUNT 32

// operation-ID ring size
`define OPID_SPACE 16

// operand width
`define DATA_W 32

`endif

/* logic/issue_pkg.sv */
`default_nettype none

`include "issue_config.svh"

package issue_pkg;

    localparam int opid_idx_w = $clog2(`OPID_SPACE);  // ring index bits
    localparam int preg_w     = $clog2(`PREG_COUNT);
    localparam int fu_mem_bit = 1;                    // fu mask bit of the LSU

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_shift,
        op_load,
        op_store
    } opcode_e;

    typedef struct packed {
        logic                  valid;
        logic [opid_idx_w-1:0] idx;    // position on the age ring
    } opid_t;

    typedef logic [preg_w-1:0] preg_t;

    typedef logic [4:0] fu_mask_t;

    typedef struct packed {
        opid_t          opid;
        fu_mask_t       fu;
        opcode_e        opcode;
        preg_t          prda;
        preg_t [1:0]    prsa;
        logic  [15:0]   imm;
    } ren_bundle_t;

    // also the payload word of the queue
    typedef struct packed {
        opid_t                        opid;
        fu_mask_t                     fu;
        opcode_e                      opcode;
        preg_t                        prda;
        logic [1:0]                   prsb;   // per-source busy
        logic [1:0][`DATA_W-1:0]      prsv;   // per-source value
        logic [15:0]                  imm;
    } iss_bundle_t;

    typedef struct packed {
        opid_t              opid;
        preg_t              prda;
        logic [`DATA_W-1:0] prdv;
    } exe_bundle_t;

    typedef struct packed {
        opid_t opid;    // mispredicted op, valid for one cycle
        opid_t topid;   // oldest op still in flight
    } red_bundle_t;

endpackage

`default_nettype wire

/* logic/issue_queue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "issue_config.svh"

module issue_queue import issue_pkg::*; (
    input  logic                                          clk,
    input  logic                                          rst,
    input  fu_mask_t                                      fu_ready,
    input  logic        [`REN_WIDTH-1:0][1:0]             busy_resp,
    input  logic        [`REN_WIDTH-1:0][1:0][`DATA_W-1:0] reg_resp,
    input  exe_bundle_t [`EXE_WIDTH-1:0]                  exe_bundle,
    input  red_bundle_t                                   red_bundle,
    output logic        [`REN_WIDTH-1:0]                  ready,
    input  ren_bundle_t [`REN_WIDTH-1:0]                  ren_bundle,
    output iss_bundle_t [`EXE_WIDTH-1:0]                  iss_bundle,
    output iss_bundle_t [`EXE_WIDTH-1:0]                  lsu_bundle
);
    localparam int idx_w    = $clog2(`IQ_DEPTH);
    localparam int cnt_w    = idx_w + 1;
    localparam int rd_ports = 2 * `EXE_WIDTH;   // alu picks then mem picks

    logic [cnt_w-1:0] iq_num;    // occupied entries
    logic [cnt_w-1:0] iq_in;     // lanes taken this cycle

    logic [`IQ_DEPTH-1:0] iq_occ;
    logic [`IQ_DEPTH-1:0] iq_ready;
    logic [`IQ_DEPTH-1:0] iq_mem;
    logic [`IQ_DEPTH-1:0] iq_resend;   // store already sent without data
    logic [`IQ_DEPTH-1:0] iq_flush;
    logic [`IQ_DEPTH-1:0] iq_out_mask; // entries freed on this edge

    opid_t    [`IQ_DEPTH-1:0]                   iq_opid;
    fu_mask_t [`IQ_DEPTH-1:0]                   iq_fu;
    preg_t    [`IQ_DEPTH-1:0][1:0]              iq_prsa;
    logic     [`IQ_DEPTH-1:0][1:0]              iq_prsb;
    logic     [`IQ_DEPTH-1:0][1:0]              prsb_fwd;
    logic     [`IQ_DEPTH-1:0][1:0][`DATA_W-1:0] iq_prsv;
    logic     [`IQ_DEPTH-1:0][1:0][`DATA_W-1:0] prsv_fwd;

    logic        [`REN_WIDTH-1:0][idx_w:0]   free_pos;
    logic        [`EXE_WIDTH-1:0][idx_w:0]   alu_pos;
    logic        [`EXE_WIDTH-1:0][idx_w:0]   mem_pos;
    logic        [rd_ports-1:0][idx_w-1:0]   raddr;
    logic        [`REN_WIDTH-1:0][idx_w-1:0] waddr;
    iss_bundle_t [rd_ports-1:0]              rvalue;
    iss_bundle_t [`REN_WIDTH-1:0]            in_bundle;

    // ring distance from the oldest op decides age
    function automatic logic younger(input opid_t id);
        logic [opid_idx_w-1:0] dist_id;
        logic [opid_idx_w-1:0] dist_red;
        dist_id  = id.idx - red_bundle.topid.idx;
        dist_red = red_bundle.opid.idx - red_bundle.topid.idx;
        return red_bundle.opid.valid && id.valid && dist_id > dist_red;
    endfunction

    // admission, in-order prefix of valid lanes
    always_comb begin
        logic take;
        take  = !rst && !red_bundle.opid.valid;   // nothing enters in reset or on a redirect
        ready = '0;
        iq_in = '0;
        for (int i = 0; i < `REN_WIDTH; i++) begin
            take     = take && ren_bundle[i].opid.valid && (i < `IQ_DEPTH - int'(iq_num));
            ready[i] = take;
            if (take) begin
                iq_in = iq_in + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `REN_WIDTH; i++) begin
            in_bundle[i].opid   = ren_bundle[i].opid;
            in_bundle[i].fu     = ren_bundle[i].fu;
            in_bundle[i].opcode = ren_bundle[i].opcode;
            in_bundle[i].prda   = ren_bundle[i].prda;
            in_bundle[i].prsb   = busy_resp[i];
            in_bundle[i].prsv   = reg_resp[i];
            in_bundle[i].imm    = ren_bundle[i].imm;
            waddr[i]            = free_pos[i][idx_w-1:0];
        end
        for (int i = 0; i < `EXE_WIDTH; i++) begin
            raddr[i]              = alu_pos[i][idx_w-1:0];
            raddr[`EXE_WIDTH + i] = mem_pos[i][idx_w-1:0];
        end
    end

    multiport_ram #(
        .width($bits(iss_bundle_t)),
        .depth(`IQ_DEPTH),
        .read_ports(rd_ports),
        .write_ports(`REN_WIDTH)
    ) payload0 (
        .clk(clk),
        .rst(rst),
        .raddr(raddr),
        .rvalue(rvalue),
        .waddr(waddr),
        .wvalue(in_bundle),
        .wena(ready)
    );

    first_k_select #(.width(`IQ_DEPTH), .k(`REN_WIDTH)) free_sel0 (
        .bits(~iq_occ),
        .pos(free_pos)
    );

    first_k_select #(.width(`IQ_DEPTH), .k(`EXE_WIDTH)) alu_sel0 (
        .bits(iq_ready & ~iq_mem),
        .pos(alu_pos)
    );

    first_k_select #(.width(`IQ_DEPTH), .k(`EXE_WIDTH)) mem_sel0 (
        .bits(iq_ready & iq_mem),
        .pos(mem_pos)
    );

    // wakeup, write-backs land in the same cycle
    always_comb begin
        prsb_fwd = iq_prsb;
        prsv_fwd = iq_prsv;
        for (int e = 0; e < `IQ_DEPTH; e++) begin
            for (int s = 0; s < 2; s++) begin
                for (int j = 0; j < `EXE_WIDTH; j++) begin
                    if (exe_bundle[j].opid.valid && exe_bundle[j].prda != '0 &&
                        iq_prsa[e][s] == exe_bundle[j].prda) begin
                        prsb_fwd[e][s] = 1'b0;
                        prsv_fwd[e][s] = exe_bundle[j].prdv;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int e = 0; e < `IQ_DEPTH; e++) begin
            iq_mem[e]   = iq_fu[e][fu_mem_bit];
            // stores may go once before their data is ready
            iq_ready[e] = iq_occ[e] && |(iq_fu[e] & fu_ready) && !prsb_fwd[e][0] &&
                          (!prsb_fwd[e][1] || (iq_mem[e] && !iq_resend[e]));
            iq_flush[e] = iq_occ[e] && younger(iq_opid[e]);
        end
    end

    always_comb begin
        iss_bundle  = '0;
        lsu_bundle  = '0;
        iq_out_mask = iq_flush;
        for (int i = 0; i < `EXE_WIDTH; i++) begin
            if (alu_pos[i][idx_w]) begin
                iss_bundle[i]      = rvalue[i];
                iss_bundle[i].opid = iq_flush[raddr[i]] ? '0 : iq_opid[raddr[i]];
                iss_bundle[i].prsb = '0;
                iss_bundle[i].prsv = prsv_fwd[raddr[i]];
                iq_out_mask[raddr[i]] = 1'b1;
            end
            if (mem_pos[i][idx_w]) begin
                lsu_bundle[i]      = rvalue[`EXE_WIDTH + i];
                lsu_bundle[i].opid = iq_flush[raddr[`EXE_WIDTH + i]] ?
                                     '0 : iq_opid[raddr[`EXE_WIDTH + i]];
                lsu_bundle[i].prsb = prsb_fwd[raddr[`EXE_WIDTH + i]];
                lsu_bundle[i].prsv = prsv_fwd[raddr[`EXE_WIDTH + i]];
                if (!prsb_fwd[raddr[`EXE_WIDTH + i]][1]) begin
                    iq_out_mask[raddr[`EXE_WIDTH + i]] = 1'b1;   // complete, leaves
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            iq_occ    <= '0;
            iq_resend <= '0;
            iq_num    <= '0;
        end else begin
            iq_num <= iq_num + iq_in - cnt_w'($countones(iq_out_mask));
            iq_occ <= iq_occ & ~iq_out_mask;
            for (int i = 0; i < `EXE_WIDTH; i++) begin
                if (mem_pos[i][idx_w]) begin
                    iq_resend[raddr[`EXE_WIDTH + i]] <= lsu_bundle[i].prsb[1];
                end
            end
            for (int i = 0; i < `REN_WIDTH; i++) begin
                if (ready[i]) begin
                    iq_occ[waddr[i]]    <= 1'b1;
                    iq_resend[waddr[i]] <= 1'b0;
                end
            end
        end
    end

    // per-entry tags and operands
    always_ff @(posedge clk) begin
        iq_prsb <= prsb_fwd;
        iq_prsv <= prsv_fwd;
        for (int i = 0; i < `REN_WIDTH; i++) begin
            if (ready[i]) begin
                iq_opid[waddr[i]] <= ren_bundle[i].opid;
                iq_fu[waddr[i]]   <= ren_bundle[i].fu;
                iq_prsa[waddr[i]] <= ren_bundle[i].prsa;
                iq_prsb[waddr[i]] <= busy_resp[i];
                iq_prsv[waddr[i]] <= reg_resp[i];
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        iq_num <= cnt_w'(`IQ_DEPTH));

    for (genvar i = 0; i < `EXE_WIDTH; i++) begin : g_iss_chk
        a_alu_from_occ: assert property (@(posedge clk) disable iff (rst)
            iss_bundle[i].opid.valid |-> iq_occ[raddr[i]]);
        a_lsu_from_occ: assert property (@(posedge clk) disable iff (rst)
            lsu_bundle[i].opid.valid |-> iq_occ[raddr[`EXE_WIDTH + i]]);
    end

endmodule

`default_nettype wire

/* logic/issue_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "issue_config.svh"

module issue_top import issue_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  ren_bundle_t [`REN_WIDTH-1:0] ren_bundle,
    output logic        [`REN_WIDTH-1:0] ready,
    input  exe_bundle_t [`EXE_WIDTH-1:0] exe_bundle,
    input  red_bundle_t                  red_bundle,
    input  fu_mask_t                     fu_ready,
    output iss_bundle_t [`EXE_WIDTH-1:0] iss_bundle,
    output iss_bundle_t [`EXE_WIDTH-1:0] lsu_bundle
);
    preg_t [`REN_WIDTH-1:0][1:0]              prsa_lanes;
    preg_t [`REN_WIDTH-1:0]                   prda_lanes;
    logic  [`REN_WIDTH-1:0][1:0]              busy_resp;
    logic  [`REN_WIDTH-1:0][1:0][`DATA_W-1:0] reg_resp;

    always_comb begin
        for (int i = 0; i < `REN_WIDTH; i++) begin
            prsa_lanes[i] = ren_bundle[i].prsa;   // register lookup per lane
            prda_lanes[i] = ren_bundle[i].prda;
        end
    end

    reg_status reg_status0 (
        .clk(clk),
        .rst(rst),
        .prsa_lanes(prsa_lanes),
        .dispatch(ready),
        .prda_lanes(prda_lanes),
        .exe_bundle(exe_bundle),
        .busy_resp(busy_resp),
        .reg_resp(reg_resp)
    );

    issue_queue issue_queue0 (
        .clk(clk),
        .rst(rst),
        .fu_ready(fu_ready),
        .busy_resp(busy_resp),
        .reg_resp(reg_resp),
        .exe_bundle(exe_bundle),
        .red_bundle(red_bundle),
        .ready(ready),
        .ren_bundle(ren_bundle),
        .iss_bundle(iss_bundle),
        .lsu_bundle(lsu_bundle)
    );

endmodule

`default_nettype wire

/* logic/multiport_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module multiport_ram #(
    parameter int width       = 32,
    parameter int depth       = 8,
    parameter int read_ports  = 2,
    parameter int write_ports = 2
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [read_ports-1:0][$clog2(depth)-1:0]   raddr,
    output logic [read_ports-1:0][width-1:0]           rvalue,
    input  logic [write_ports-1:0][$clog2(depth)-1:0]  waddr,
    input  logic [write_ports-1:0][width-1:0]          wvalue,
    input  logic [write_ports-1:0]                     wena
);
    logic [width-1:0] mem [depth];

    always_comb begin
        for (int r = 0; r < read_ports; r++) begin
            rvalue[r] = mem[raddr[r]];    // async read
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < write_ports; w++) begin
            if (wena[w]) begin
                mem[waddr[w]] <= wvalue[w];
            end
        end
    end

    // callers must never aim two writes at one word
    for (genvar a = 0; a < write_ports; a++) begin : g_wr_pair
        for (genvar b = a + 1; b < write_ports; b++) begin : g_wr_other
            a_wr_conflict: assert property (@(posedge clk) disable iff (rst)
                !(wena[a] && wena[b] && waddr[a] == waddr[b]));
        end
    end

endmodule

`default_nettype wire

/* logic/reg_status.sv */
`timescale 1ns/10ps
`default_nettype none

`include "issue_config.svh"

module reg_status import issue_pkg::*; (
    input  logic                                          clk,
    input  logic                                          rst,
    input  preg_t       [`REN_WIDTH-1:0][1:0]             prsa_lanes,
    input  logic        [`REN_WIDTH-1:0]                  dispatch,
    input  preg_t       [`REN_WIDTH-1:0]                  prda_lanes,
    input  exe_bundle_t [`EXE_WIDTH-1:0]                  exe_bundle,
    output logic        [`REN_WIDTH-1:0][1:0]             busy_resp,
    output logic        [`REN_WIDTH-1:0][1:0][`DATA_W-1:0] reg_resp
);
    logic [`PREG_COUNT-1:0]              busy;   // busy table
    logic [`PREG_COUNT-1:0][`DATA_W-1:0] regs;   // physical register file

    function automatic logic wb_hit(input exe_bundle_t wb, input preg_t p);
        return wb.opid.valid && wb.prda != '0 && wb.prda == p;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            regs <= '0;
        end else begin
            for (int j = 0; j < `EXE_WIDTH; j++) begin
                if (wb_hit(exe_bundle[j], exe_bundle[j].prda)) begin
                    busy[exe_bundle[j].prda] <= 1'b0;
                    regs[exe_bundle[j].prda] <= exe_bundle[j].prdv;
                end
            end
            for (int i = 0; i < `REN_WIDTH; i++) begin
                if (dispatch[i] && prda_lanes[i] != '0) begin
                    busy[prda_lanes[i]] <= 1'b1;   // new destination pending
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `REN_WIDTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                busy_resp[i][s] = busy[prsa_lanes[i][s]];
                reg_resp[i][s]  = regs[prsa_lanes[i][s]];
                for (int j = 0; j < `EXE_WIDTH; j++) begin
                    if (wb_hit(exe_bundle[j], prsa_lanes[i][s])) begin
                        busy_resp[i][s] = 1'b0;               // same-cycle bypass
                        reg_resp[i][s]  = exe_bundle[j].prdv;
                    end
                end
                // producer in an earlier lane of this bundle
                for (int m = 0; m < i; m++) begin
                    if (dispatch[m] && prda_lanes[m] == prsa_lanes[i][s]) begin
                        busy_resp[i][s] = 1'b1;
                    end
                end
                if (prsa_lanes[i][s] == '0) begin
                    busy_resp[i][s] = 1'b0;   // p0 reads zero
                    reg_resp[i][s]  = '0;
                end
            end
        end
    end

    for (genvar a = 0; a < `EXE_WIDTH; a++) begin : g_wb_pair
        for (genvar b = a + 1; b < `EXE_WIDTH; b++) begin : g_wb_other
            a_wb_unique: assert property (@(posedge clk) disable iff (rst)
                !(wb_hit(exe_bundle[a], exe_bundle[a].prda) &&
                  wb_hit(exe_bundle[b], exe_bundle[a].prda)));
        end
    end

endmodule

`default_nettype wire

/* tests/issue_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "issue_config.svh"

module issue_tb import issue_pkg::*;;
    localparam fu_mask_t alu = 5'b00001;
    localparam fu_mask_t mem = 5'b00010;
    localparam int n_rows = 28;
    localparam int n_tests = 4;

    typedef struct packed {
        opcode_e    op;
        fu_mask_t   fu;
        preg_t      prda;
        preg_t      src0;
        preg_t      src1;
        logic       split;   // store expected on lsu once before its data
        logic [7:0] wb;      // cycles from issue to write-back
    } row_t;

    row_t rows [n_rows] = '{
        '{op_add,   alu, 5'd1,  5'd0,  5'd0,  1'b0, 8'd3},   // dependent chain
        '{op_sub,   alu, 5'd2,  5'd1,  5'd0,  1'b0, 8'd1},
        '{op_and,   alu, 5'd3,  5'd1,  5'd2,  1'b0, 8'd2},
        '{op_or,    alu, 5'd4,  5'd0,  5'd0,  1'b0, 8'd4},
        '{op_xor,   alu, 5'd5,  5'd3,  5'd4,  1'b0, 8'd1},
        '{op_shift, alu, 5'd6,  5'd5,  5'd5,  1'b0, 8'd2},
        '{op_add,   alu, 5'd7,  5'd6,  5'd1,  1'b0, 8'd1},
        '{op_sub,   alu, 5'd8,  5'd7,  5'd2,  1'b0, 8'd3},
        '{op_add,   alu, 5'd9,  5'd1,  5'd2,  1'b0, 8'd1},   // back-pressure
        '{op_sub,   alu, 5'd10, 5'd1,  5'd2,  1'b0, 8'd1},
        '{op_and,   alu, 5'd11, 5'd1,  5'd2,  1'b0, 8'd1},
        '{op_or,    alu, 5'd12, 5'd1,  5'd2,  1'b0, 8'd1},
        '{op_xor,   alu, 5'd13, 5'd1,  5'd2,  1'b0, 8'd1},
        '{op_add,   alu, 5'd14, 5'd1,  5'd2,  1'b0, 8'd1},
        '{op_sub,   alu, 5'd15, 5'd1,  5'd2,  1'b0, 8'd1},
        '{op_and,   alu, 5'd16, 5'd1,  5'd2,  1'b0, 8'd1},
        '{op_or,    alu, 5'd17, 5'd1,  5'd2,  1'b0, 8'd1},
        '{op_xor,   alu, 5'd18, 5'd1,  5'd2,  1'b0, 8'd1},
        '{op_add,   alu, 5'd20, 5'd1,  5'd0,  1'b0, 8'd8},   // store data producer
        '{op_store, mem, 5'd0,  5'd2,  5'd20, 1'b1, 8'd0},
        '{op_add,   alu, 5'd21, 5'd20, 5'd0,  1'b0, 8'd1},
        '{op_store, mem, 5'd0,  5'd21, 5'd20, 1'b0, 8'd0},
        '{op_add,   alu, 5'd22, 5'd1,  5'd0,  1'b0, 8'd10},  // redirect victims wait on p22
        '{op_add,   alu, 5'd23, 5'd22, 5'd0,  1'b0, 8'd1},
        '{op_sub,   alu, 5'd24, 5'd22, 5'd1,  1'b0, 8'd1},
        '{op_xor,   alu, 5'd25, 5'd22, 5'd0,  1'b0, 8'd1},
        '{op_or,    alu, 5'd26, 5'd22, 5'd2,  1'b0, 8'd1},
        '{op_and,   alu, 5'd27, 5'd23, 5'd0,  1'b0, 8'd1}
    };

    string t_name [n_tests] = '{"issue", "backpressure", "store", "redirect"};
    int t_first [n_tests] = '{0, 8, 18, 22};
    int t_num   [n_tests] = '{8, 10, 4, 6};
    int t_gaps  [n_tests] = '{1, 0, 0, 0};    // random fu_ready gaps
    int t_hold  [n_tests] = '{0, 12, 0, 0};   // cycles with fu_ready low
    int t_red   [n_tests] = '{-1, -1, -1, 2}; // table position of the redirect op

    logic clk;
    logic rst;
    ren_bundle_t [`REN_WIDTH-1:0] ren_bundle;
    logic        [`REN_WIDTH-1:0] ready;
    exe_bundle_t [`EXE_WIDTH-1:0] exe_bundle;
    red_bundle_t                  red_bundle;
    fu_mask_t                     fu_ready;
    iss_bundle_t [`EXE_WIDTH-1:0] iss_bundle;
    iss_bundle_t [`EXE_WIDTH-1:0] lsu_bundle;

    logic [31:0] lfsr = 32'hf31f;
    logic              busy_m [`PREG_COUNT];   // register model
    logic [`DATA_W-1:0] val_m [`PREG_COUNT];
    int iss_cnt [16];
    int part_cnt [16];
    int done_cnt [16];
    preg_t pend_p [$];     // write-backs still owed
    opid_t pend_id [$];
    int    pend_due [$];
    int cyc = 0;
    int checks = 0;
    int errors = 0;
    int cur_first, cur_n, cur_red, cur_next;
    logic red_done;

    issue_top dut0 (
        .clk(clk), .rst(rst), .ren_bundle(ren_bundle), .ready(ready),
        .exe_bundle(exe_bundle), .red_bundle(red_bundle), .fu_ready(fu_ready),
        .iss_bundle(iss_bundle), .lsu_bundle(lsu_bundle)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 32'h80200003;
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic ren_bundle_t make_ren(input row_t rw, input int id);
        ren_bundle_t b;
        b.opid   = '{valid: 1'b1, idx: opid_idx_w'(id)};
        b.fu     = rw.fu;
        b.opcode = rw.op;
        b.prda   = rw.prda;
        b.prsa   = {rw.src1, rw.src0};
        b.imm    = 16'(id);
        return b;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("error t=%0t %s expected %h observed %h", $time, name, exp, got);
        end
    endtask

    task automatic fail(input string msg);
        checks++;
        errors++;
        $display("t=%0t %s", $time, msg);
    endtask

    task automatic drive_writebacks();
        int i;
        int lane;
        i = 0;
        lane = 0;
        exe_bundle = '0;
        while (i < pend_p.size()) begin
            if (lane < `EXE_WIDTH && pend_due[i] <= cyc) begin
                exe_bundle[lane].opid = pend_id[i];
                exe_bundle[lane].prda = pend_p[i];
                exe_bundle[lane].prdv = lfsr_bits(`DATA_W);
                val_m[pend_p[i]]  = exe_bundle[lane].prdv;   // visible to same-cycle issue
                busy_m[pend_p[i]] = 1'b0;
                pend_p.delete(i);
                pend_id.delete(i);
                pend_due.delete(i);
                lane++;
            end else begin
                i++;
            end
        end
    endtask

    task automatic check_lane(input iss_bundle_t b, input logic on_lsu);
        int pos;
        row_t rw;
        pos = int'(opid_idx_w'(b.opid.idx - opid_idx_w'(cur_first)));
        if (pos >= cur_n) begin
            fail("an op that was never dispatched came out");
            return;
        end
        rw = rows[cur_first + pos];
        if (on_lsu != (rw.fu == mem)) fail("op came out on the wrong issue bundle");
        if (red_done && cur_red >= 0 && pos > cur_red) fail("flushed op issued after redirect");
        compare("prsb[0]", 32'(busy_m[rw.src0]), 32'(b.prsb[0]));
        compare("prsb[1]", 32'(busy_m[rw.src1]), 32'(b.prsb[1]));
        compare("opcode", 32'(rw.op), 32'(b.opcode));
        compare("fu", 32'(rw.fu), 32'(b.fu));
        compare("prda", 32'(rw.prda), 32'(b.prda));
        compare("imm", 32'(16'(cur_first + pos)), 32'(b.imm));
        if (on_lsu && b.prsb[1]) begin
            part_cnt[pos]++;
            if (part_cnt[pos] > 1) fail("store went out twice without its data");
            if (done_cnt[pos] > 0) fail("store seen again after its complete issue");
            return;
        end
        if (busy_m[rw.src0] || busy_m[rw.src1]) fail("op issued with a source still busy");
        compare("prsv[0]", val_m[rw.src0], b.prsv[0]);
        compare("prsv[1]", val_m[rw.src1], b.prsv[1]);
        if (on_lsu) begin
            done_cnt[pos]++;
            if (done_cnt[pos] > 1) fail("store issued twice");
        end else begin
            iss_cnt[pos]++;
            if (iss_cnt[pos] > 1) fail("op issued twice");
            pend_p.push_back(rw.prda);
            pend_id.push_back(b.opid);
            pend_due.push_back(cyc + int'(rw.wb));
        end
    endtask

    function automatic logic all_done();
        int exp;
        if (cur_next < cur_n || (cur_red >= 0 && !red_done) || pend_p.size() != 0) return 1'b0;
        for (int p = 0; p < cur_n; p++) begin
            exp = (cur_red < 0 || p <= cur_red) ? 1 : 0;
            if (iss_cnt[p] + done_cnt[p] != exp) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic run_test(input int t);
        int inq;
        int tc;
        int quiet;
        logic offered;
        logic red_now;
        logic saw_full;
        int errs0;
        row_t rw;
        errs0 = errors;
        cur_first = t_first[t];
        cur_n = t_num[t];
        cur_red = t_red[t];
        cur_next = 0;
        red_done = 1'b0;
        inq = 0;
        tc = 0;
        quiet = 0;
        saw_full = 1'b0;
        for (int p = 0; p < 16; p++) begin
            iss_cnt[p] = 0;
            part_cnt[p] = 0;
            done_cnt[p] = 0;
        end
        while (quiet < 4) begin
            @(posedge clk);
            #2;
            red_now = cur_red >= 0 && !red_done && cur_next == cur_n;
            if (tc < t_hold[t]) fu_ready = '0;
            else if (t_gaps[t] != 0 && lfsr_bits(2) == 2'b11) fu_ready = '0;
            else fu_ready = '1;
            ren_bundle = '0;
            red_bundle = '0;
            offered = 1'b0;
            if (red_now) begin
                ren_bundle[0] = make_ren(rows[cur_first], cur_first + cur_n);  // must be refused
                red_bundle.opid  = '{valid: 1'b1, idx: opid_idx_w'(cur_first + cur_red)};
                red_bundle.topid = '{valid: 1'b1, idx: opid_idx_w'(cur_first)};
                red_done = 1'b1;
            end else if (cur_next < cur_n) begin
                ren_bundle[0] = make_ren(rows[cur_first + cur_next], cur_first + cur_next);
                offered = 1'b1;
            end
            drive_writebacks();
            #8;
            if (red_now) compare("ready", 0, 32'(ready));
            for (int l = 0; l < `EXE_WIDTH; l++) begin
                if (iss_bundle[l].opid.valid) check_lane(iss_bundle[l], 1'b0);
                if (lsu_bundle[l].opid.valid) check_lane(lsu_bundle[l], 1'b1);
            end
            if (offered && ready[0]) begin
                rw = rows[cur_first + cur_next];
                if (rw.prda != '0) busy_m[rw.prda] = 1'b1;
                cur_next++;
                if (tc < t_hold[t]) inq++;
                if (inq > `IQ_DEPTH) fail("queue accepted more ops than it holds");
            end
            if (offered && !ready[0] && tc < t_hold[t] && inq == `IQ_DEPTH) saw_full = 1'b1;
            if (t_hold[t] > 0 && tc == t_hold[t] - 1) begin
                compare("accepted while stalled", `IQ_DEPTH, inq);
                if (!saw_full) fail("ready never fell with the queue full");
            end
            tc++;
            if (all_done()) quiet++;
        end
        for (int p = 0; p < cur_n; p++) begin
            rw = rows[cur_first + p];
            compare("issue count", (cur_red < 0 || p <= cur_red) ? 1 : 0,
                    rw.fu == mem ? done_cnt[p] : iss_cnt[p]);
            if (rw.split && part_cnt[p] == 0) fail("store never went out before its data");
        end
        $display("test %s finished, %0d errors", t_name[t], errors - errs0);
    endtask

    // watchdog, limit follows the table length
    initial begin
        int limit;
        limit = 4 * n_rows + 50;
        for (int r = 0; r < n_rows; r++) limit += int'(rows[r].wb);
        while (cyc < limit) begin
            @(posedge clk);
            cyc++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", limit);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        ren_bundle[0] = make_ren(rows[0], 0);   // offers that reset must refuse
        ren_bundle[1] = make_ren(rows[1], 1);
        exe_bundle = '0;
        red_bundle = '0;
        fu_ready = '0;
        for (int p = 0; p < `PREG_COUNT; p++) begin
            busy_m[p] = 1'b0;
            val_m[p] = '0;
        end
        repeat (3) begin
            @(posedge clk);
            #2;
            compare("ready in reset", 0, 32'(ready));
        end
        ren_bundle = '0;
        rst = 1'b0;
        for (int t = 0; t < n_tests; t++) run_test(t);
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
